// ==== include/control_defs.svh ====
// Field widths assume the 8-bit opcode/condition byte; flag bit positions must match the ALU flag bus
`ifndef CONTROL_DEFS_SVH
`define CONTROL_DEFS_SVH

// Instruction byte fields
`define OPCODE_WIDTH 5             // Byte bits 7 to 3
`define COND_WIDTH 3               // Byte bits 2 to 0

// ALU flag bus
`define FLAG_WIDTH 4

// Bit positions in the flag register
`define FLAGS_C 0                  // Carry
`define FLAGS_Z 1                  // Zero
`define FLAGS_N 2                  // Negative
`define FLAGS_V 3                  // Overflow

`endif

// ==== verilog/opcodePkg.sv ====
// Opcodes are encoded in list order from zero; codes above BRANCH are unused and decode to no-ops
`include "control_defs.svh"

package opcodePkg;

   // Upper five bits of the instruction byte
   typedef enum logic [`OPCODE_WIDTH-1:0] {
      ADD,
      ADDI,
      ADDIB,
      ADC,
      ADCI,
      SUB,
      SUBI,
      SUBIB,
      SUC,
      SUCI,
      CMP,
      CMPI,
      NEG,
      AND,
      OR,
      XOR,
      NOT,
      NAND,
      NOR,
      LSL,
      LSR,
      ASR,
      LUI,
      LLI,
      LDW,
      STW,
      BRANCH                       // Sub-decoded by the branch code
   } opcodeT;

   // Lower three bits, only meaningful with BRANCH
   typedef enum logic [`COND_WIDTH-1:0] {BR, BNE, BE, BLT, BGE, BWL, RET, JMP} branchT;

endpackage

// ==== verilog/controlPkg.sv ====
// Select encodings must match the datapath multiplexers; Idle is the step held only during reset
package controlPkg;

   typedef enum logic [3:0] {
      FnA,                         // Pass operand 1
      FnADD,
      FnADC,
      FnSUB,
      FnNEG,
      FnAND,
      FnOR,
      FnXOR,
      FnNOT,
      FnNAND,
      FnNOR,
      FnLSL,
      FnLSR,
      FnASR,
      FnLUI,
      FnLLI
   } aluFunctionT;

   // Datapath multiplexer selects
   typedef enum logic {Op1Rd1, Op1Pc} op1SelectT;
   typedef enum logic {Op2Imm, Op2Rd2} op2SelectT;
   typedef enum logic {ImmShort, ImmLong} immSelectT;
   typedef enum logic {Rs1Ra, Rs1Rd} rs1SelectT;
   typedef enum logic {WdAlu, WdSys} wdSelectT;
   typedef enum logic [1:0] {Pc1, PcAluOut, PcSysbus} pcSelectT;
   typedef enum logic {LrPc} lrSelectT;    // Link register loads only from the PC

   // Sequencer state
   typedef enum logic {Fetch, Execute} phaseT;
   typedef enum logic [2:0] {
      Cycle0,
      Cycle1,
      Cycle2,
      Cycle3,
      Cycle4,
      Idle = 3'd7                  // Reset hold, all strobes inactive
   } stepT;

endpackage

// ==== verilog/statusFlags.sv ====
// Flags are captured only when StatusWe is high at the clock edge; branch tests use stored flags
`timescale 1ns/1ps
`include "control_defs.svh"

module statusFlags (
   input  logic                    Clock,
   input  logic                    nReset,
   input  logic [`FLAG_WIDTH-1:0]  Flags,
   input  logic                    StatusWe,
   input  opcodePkg::branchT       BranchCode,
   output logic                    BranchTaken,
   output logic                    CFlag
);

   import opcodePkg::*;

   logic [`FLAG_WIDTH-1:0] StatusReg;

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         StatusReg <= '0;
      end else if (StatusWe) begin
         StatusReg <= Flags;
      end
   end

   assign CFlag = StatusReg[`FLAGS_C];   // Carry into ADC/SUC

   always_comb begin
      BranchTaken = 1'b1;               // BR, BWL, RET, JMP
      case (BranchCode)
         BE:      BranchTaken = StatusReg[`FLAGS_Z];
         BNE:     BranchTaken = !StatusReg[`FLAGS_Z];
         BLT:     BranchTaken = StatusReg[`FLAGS_N] ^ StatusReg[`FLAGS_V];
         BGE:     BranchTaken = !(StatusReg[`FLAGS_N] ^ StatusReg[`FLAGS_V]);
         default: ;
      endcase
   end

endmodule

// ==== verilog/cycleSequencer.sv ====
// Steps advance one per clock; reset holds Fetch/Idle so the first clock after release is Fetch Cycle0
`timescale 1ns/1ps

module cycleSequencer (
   input  logic               Clock,
   input  logic               nReset,
   input  opcodePkg::opcodeT  Opcode,
   input  logic               nWait,
   output controlPkg::phaseT  Phase,
   output controlPkg::stepT   Step
);

   import opcodePkg::*;
   import controlPkg::*;

   logic MemOp;

   assign MemOp = Opcode inside {LDW, STW};   // Only multi-cycle execute

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         Phase <= Fetch;
         Step  <= Idle;
      end else if (Phase == Fetch) begin
         case (Step)
            Cycle0: Step <= Cycle1;
            Cycle1: Step <= Cycle2;
            Cycle2: if (nWait) begin   // Memory read may stretch
               Step <= Cycle3;
            end
            Cycle3: begin
               Phase <= Execute;
               Step  <= Cycle0;
            end
            default: Step <= Cycle0;   // Leaving reset
         endcase
      end else begin
         case (Step)
            Cycle0: if (MemOp) begin
               Step <= Cycle1;
            end else begin
               Phase <= Fetch;         // Single cycle ops
            end
            Cycle1: Step <= Cycle2;
            Cycle2: Step <= Cycle3;
            Cycle3: if (nWait) begin   // Data access wait state
               Step <= Cycle4;
            end
            default: begin
               Phase <= Fetch;
               Step  <= Cycle0;
            end
         endcase
      end
   end

   assert property (@(posedge Clock) disable iff (!nReset) !(Phase == Fetch && Step == Cycle4))
      else $error("Fetch phase reached Cycle4");

   // A low nWait in a wait step freezes the whole state for the next cycle
   assert property (@(posedge Clock) disable iff (!nReset)
      (!nWait && ((Phase == Fetch && Step == Cycle2) || (Phase == Execute && Step == Cycle3)))
      |=> ($stable(Step) && $stable(Phase)))
      else $error("Step moved during nWait stall");

endmodule

// ==== verilog/datapathDecoder.sv ====
// Purely combinational; outputs are only valid once Phase, Step and the opcode fields have settled
`timescale 1ns/1ps

module datapathDecoder (
   input  controlPkg::phaseT         Phase,
   input  controlPkg::stepT          Step,
   input  opcodePkg::opcodeT         Opcode,
   input  opcodePkg::branchT         BranchCode,
   input  logic                      BranchTaken,
   output controlPkg::aluFunctionT   AluOp,
   output controlPkg::op1SelectT     Op1Sel,
   output controlPkg::op2SelectT     Op2Sel,
   output controlPkg::immSelectT     ImmSel,
   output controlPkg::rs1SelectT     Rs1Sel,
   output controlPkg::wdSelectT      WdSel,
   output controlPkg::pcSelectT      PcSel,
   output controlPkg::lrSelectT      LrSel,
   output logic                      AluEn,
   output logic                      AluWe,
   output logic                      RegWe,
   output logic                      PcWe,
   output logic                      PcEn,
   output logic                      IrWe,
   output logic                      LrEn,
   output logic                      LrWe,
   output logic                      StatusWe
);

   import opcodePkg::*;
   import controlPkg::*;

   function automatic aluFunctionT aluFunction(opcodeT Op);
      case (Op)
         ADD, ADDI, ADDIB:                return FnADD;
         ADC, ADCI, SUC, SUCI:            return FnADC;   // Carry-in variants
         SUB, SUBI, SUBIB, CMP, CMPI:     return FnSUB;
         NEG:                             return FnNEG;
         AND:                             return FnAND;
         OR:                              return FnOR;
         XOR:                             return FnXOR;
         NOT:                             return FnNOT;
         NAND:                            return FnNAND;
         NOR:                             return FnNOR;
         LSL:                             return FnLSL;
         LSR:                             return FnLSR;
         ASR:                             return FnASR;
         LUI:                             return FnLUI;
         LLI:                             return FnLLI;
         default:                         return FnA;
      endcase
   endfunction

   always_comb begin
      // Idle control word
      AluOp    = FnA;
      Op1Sel   = Op1Rd1;
      Op2Sel   = Op2Imm;
      ImmSel   = ImmLong;
      Rs1Sel   = Rs1Ra;
      WdSel    = WdAlu;
      PcSel    = Pc1;
      LrSel    = LrPc;
      AluEn    = 1'b0;
      AluWe    = 1'b0;
      RegWe    = 1'b0;
      PcWe     = 1'b0;
      PcEn     = 1'b0;
      IrWe     = 1'b0;
      LrEn     = 1'b0;
      LrWe     = 1'b0;
      StatusWe = 1'b0;
      if (Phase == Fetch) begin
         case (Step)
            Cycle0:  PcEn = 1'b1;      // PC drives the fetch address
            Cycle3:  IrWe = 1'b1;
            default: ;
         endcase
      end else begin
         case (Step)
            Cycle0: begin
               case (Opcode)
                  ADD, ADDI, ADDIB, ADC, ADCI, SUB, SUBI, SUBIB, SUC, SUCI, CMP, CMPI, NEG,
                  AND, OR, XOR, NOT, NAND, NOR, LSL, LSR, ASR, LUI, LLI: begin
                     AluOp    = aluFunction(Opcode);
                     RegWe    = !(Opcode inside {CMP, CMPI});   // Compare keeps flags only
                     AluEn    = Opcode inside {LUI, LLI};
                     PcEn     = 1'b1;
                     PcWe     = 1'b1;
                     StatusWe = 1'b1;
                     case (Opcode)
                        ADD, ADC, SUB, SUC, CMP, AND, OR, XOR, NAND, NOR: Op2Sel = Op2Rd2;
                        ADDI, ADCI, SUBI, SUCI, CMPI, LSL, LSR, ASR:      ImmSel = ImmShort;
                        ADDIB, SUBIB, LUI, LLI:                           Rs1Sel = Rs1Rd;
                        default: ;
                     endcase
                  end
                  LDW, STW: begin
                     AluOp  = FnADD;   // Effective address
                     ImmSel = ImmShort;
                     AluWe  = 1'b1;
                     AluEn  = 1'b1;
                  end
                  BRANCH: begin
                     PcWe = 1'b1;
                     case (BranchCode)
                        RET: begin
                           LrEn  = 1'b1;
                           PcSel = PcSysbus;
                        end
                        JMP: begin
                           AluOp  = FnADD;
                           ImmSel = ImmShort;
                           PcSel  = PcAluOut;
                        end
                        default: begin   // PC-relative group
                           AluOp  = FnADD;
                           Op1Sel = Op1Pc;
                           AluEn  = 1'b1;
                           if (BranchTaken) begin
                              PcSel = PcAluOut;
                              LrWe  = (BranchCode == BWL);
                           end
                        end
                     endcase
                  end
                  default: ;
               endcase
            end
            Cycle1: begin               // Address held for ALE
               AluOp  = FnADD;
               ImmSel = ImmShort;
               AluEn  = 1'b1;
            end
            Cycle2: begin
               Rs1Sel = Rs1Rd;          // Store data through the ALU
               AluWe  = 1'b1;
               AluEn  = 1'b1;
            end
            Cycle3: AluEn = (Opcode == STW);
            Cycle4: begin
               PcWe = 1'b1;
               if (Opcode == LDW) begin
                  RegWe = 1'b1;
                  WdSel = WdSys;
               end else begin
                  AluEn = 1'b1;
               end
            end
            default: ;
         endcase
      end
   end

   // Sampled at the falling edge, Phase is still the one of the writing step
   assert property (@(negedge RegWe) Phase == Execute)
      else $error("RegWe high in a fetch step");

endmodule

// ==== verilog/busStrobes.sv ====
// Strobes are active low except ALE and ENB; fetch and LDW/STW share one four-step bus pattern
`timescale 1ns/1ps

module busStrobes (
   input  controlPkg::phaseT  Phase,
   input  controlPkg::stepT   Step,
   input  opcodePkg::opcodeT  Opcode,
   output logic               nWE,
   output logic               nOE,
   output logic               nME,
   output logic               ENB,
   output logic               ALE,
   output logic               MemEn
);

   import opcodePkg::*;
   import controlPkg::*;

   logic BusActive;
   logic BusWrite;
   stepT BusStep;

   always_comb begin
      BusActive = 1'b0;
      BusWrite  = 1'b0;
      BusStep   = Cycle0;
      if (Phase == Fetch && Step != Idle) begin
         BusActive = 1'b1;
         BusStep   = Step;
      end else if (Phase == Execute && Opcode inside {LDW, STW} && Step != Cycle0) begin
         BusActive = 1'b1;           // Data access trails the address add by one step
         BusWrite  = (Opcode == STW);
         BusStep   = stepT'(Step - 3'd1);
      end
   end

   always_comb begin
      nWE   = 1'b1;
      nOE   = 1'b1;
      nME   = 1'b1;
      ENB   = 1'b0;
      ALE   = 1'b0;
      MemEn = 1'b0;
      if (BusActive) begin
         case (BusStep)
            Cycle0: ALE = 1'b1;
            Cycle1, Cycle2: begin
               nME   = 1'b0;
               nWE   = !BusWrite;
               nOE   = BusWrite;
               MemEn = !BusWrite;   // Pads turn inward for reads
               ENB   = !BusWrite && (BusStep == Cycle2);
            end
            Cycle3: MemEn = !BusWrite;
            default: ;
         endcase
      end
   end

   assert property (@(negedge ALE) nME)
      else $error("ALE overlapped a memory cycle");

endmodule

// ==== verilog/controlTop.sv ====
// Control unit top; OpcodeCondIn must hold the current instruction from the IR through execute
`timescale 1ns/1ps
`include "control_defs.svh"

module controlTop (
   input  logic                              Clock,
   input  logic                              nReset,
   input  logic [`OPCODE_WIDTH+`COND_WIDTH-1:0] OpcodeCondIn,
   input  logic [`FLAG_WIDTH-1:0]             Flags,
   input  logic                              nWait,
   output controlPkg::aluFunctionT           AluOp,
   output controlPkg::op1SelectT             Op1Sel,
   output controlPkg::op2SelectT             Op2Sel,
   output controlPkg::immSelectT             ImmSel,
   output controlPkg::rs1SelectT             Rs1Sel,
   output controlPkg::wdSelectT              WdSel,
   output controlPkg::pcSelectT              PcSel,
   output controlPkg::lrSelectT              LrSel,
   output logic                              AluEn,
   output logic                              AluWe,
   output logic                              RegWe,
   output logic                              PcWe,
   output logic                              PcEn,
   output logic                              IrWe,
   output logic                              LrEn,
   output logic                              LrWe,
   output logic                              MemEn,
   output logic                              nWE,
   output logic                              nOE,
   output logic                              nME,
   output logic                              ENB,
   output logic                              ALE,
   output logic                              CFlag
);

   import opcodePkg::*;
   import controlPkg::*;

   opcodeT Opcode;
   branchT BranchCode;
   phaseT  Phase;
   stepT   Step;
   logic   StatusWe;
   logic   BranchTaken;

   // The only place the instruction byte is split
   assign Opcode = opcodeT'(OpcodeCondIn[`OPCODE_WIDTH+`COND_WIDTH-1:`COND_WIDTH]);
   assign BranchCode = branchT'(OpcodeCondIn[`COND_WIDTH-1:0]);

   cycleSequencer sequencer (
      .Clock  (Clock),
      .nReset (nReset),
      .Opcode (Opcode),
      .nWait  (nWait),
      .Phase  (Phase),
      .Step   (Step)
   );

   datapathDecoder decoder (
      .Phase       (Phase),
      .Step        (Step),
      .Opcode      (Opcode),
      .BranchCode  (BranchCode),
      .BranchTaken (BranchTaken),
      .AluOp       (AluOp),
      .Op1Sel      (Op1Sel),
      .Op2Sel      (Op2Sel),
      .ImmSel      (ImmSel),
      .Rs1Sel      (Rs1Sel),
      .WdSel       (WdSel),
      .PcSel       (PcSel),
      .LrSel       (LrSel),
      .AluEn       (AluEn),
      .AluWe       (AluWe),
      .RegWe       (RegWe),
      .PcWe        (PcWe),
      .PcEn        (PcEn),
      .IrWe        (IrWe),
      .LrEn        (LrEn),
      .LrWe        (LrWe),
      .StatusWe    (StatusWe)
   );

   busStrobes strobes (
      .Phase  (Phase),
      .Step   (Step),
      .Opcode (Opcode),
      .nWE    (nWE),
      .nOE    (nOE),
      .nME    (nME),
      .ENB    (ENB),
      .ALE    (ALE),
      .MemEn  (MemEn)
   );

   statusFlags flags (
      .Clock       (Clock),
      .nReset      (nReset),
      .Flags       (Flags),
      .StatusWe    (StatusWe),
      .BranchCode  (BranchCode),
      .BranchTaken (BranchTaken),
      .CFlag       (CFlag)
   );

endmodule

// ==== sim/controlTb.sv ====
// Needs simulator timing support; instruction bytes are presented from fetch Cycle1, stops at first error
`timescale 1ns/1ps
`include "control_defs.svh"

module controlTb;

   import opcodePkg::*;
   import controlPkg::*;

   localparam int TimeoutCycles = 16;   // Longest legal gap between strobes is 9

   logic                                 Clock = 1'b0;
   logic                                 nReset;
   logic [`OPCODE_WIDTH+`COND_WIDTH-1:0] OpcodeCondIn;
   logic [`FLAG_WIDTH-1:0]               Flags;
   logic                                 nWait;
   aluFunctionT AluOp;
   op1SelectT   Op1Sel;
   op2SelectT   Op2Sel;
   immSelectT   ImmSel;
   rs1SelectT   Rs1Sel;
   wdSelectT    WdSel;
   pcSelectT    PcSel;
   lrSelectT    LrSel;
   logic AluEn, AluWe, RegWe, PcWe, PcEn, IrWe, LrEn, LrWe, MemEn;
   logic nWE, nOE, nME, ENB, ALE, CFlag;
   int cycleCount = 0;
   int errorCount = 0;
   int seed;

   controlTop dut (.*);

   always #20 Clock = ~Clock;
   always @(posedge Clock) cycleCount <= cycleCount + 1;

   task automatic abortRun(input string line);
      errorCount++;
      $display("%s", line);
      $display("Simulation finished: FAIL");
      $fatal(1, "Stopped at the first error");
   endtask

   task automatic reportMismatch(input string what);
      abortRun($sformatf("FAIL at time %0t: %s", $time, what));
   endtask

   task automatic checkBit(input logic actual, input logic expected, input string name);
      if (actual !== expected)
         reportMismatch($sformatf("%s is %b, expected %b", name, actual, expected));
   endtask

   task automatic checkAluOp(input aluFunctionT actual, input aluFunctionT expected,
                             input string name);
      if (actual !== expected)
         reportMismatch({name, ": AluOp ", actual.name(), ", expected ", expected.name()});
   endtask

   task automatic checkPcSel(input pcSelectT actual, input pcSelectT expected,
                             input string name);
      if (actual !== expected)
         reportMismatch({name, ": PcSel ", actual.name(), ", expected ", expected.name()});
   endtask

   task automatic checkWdSel(input wdSelectT actual, input wdSelectT expected,
                             input string name);
      if (actual !== expected)
         reportMismatch({name, ": WdSel ", actual.name(), ", expected ", expected.name()});
   endtask

   task automatic checkImmSel(input immSelectT actual, input immSelectT expected,
                              input string name);
      if (actual !== expected)
         reportMismatch({name, ": ImmSel ", actual.name(), ", expected ", expected.name()});
   endtask

   task automatic checkCount(input int actual, input int expected, input string name);
      if (actual != expected)
         reportMismatch($sformatf("%s took %0d cycles, expected %0d", name, actual, expected));
   endtask

   task automatic waitForAle();
      int waited;
      waited = 0;
      @(negedge Clock);
      while (!ALE) begin
         if (waited == TimeoutCycles) abortRun("Timed out waiting for ALE to go high");
         waited++;
         @(negedge Clock);
      end
   endtask

   task automatic waitForIrWe();
      int waited;
      waited = 0;
      @(negedge Clock);
      while (!IrWe) begin
         if (waited == TimeoutCycles) abortRun("Timed out waiting for IrWe to go high");
         waited++;
         @(negedge Clock);
      end
   endtask

   function automatic logic [7:0] instructionByte(input opcodeT op, input branchT code);
      return {op, code};
   endfunction

   function automatic aluFunctionT expectedFunction(input opcodeT op);
      case (op)
         ADD, ADDI, ADDIB:            return FnADD;
         ADC, ADCI, SUC, SUCI:        return FnADC;
         SUB, SUBI, SUBIB, CMP, CMPI: return FnSUB;
         NEG:                         return FnNEG;
         AND:                         return FnAND;
         OR:                          return FnOR;
         XOR:                         return FnXOR;
         NOT:                         return FnNOT;
         NAND:                        return FnNAND;
         NOR:                         return FnNOR;
         LSL:                         return FnLSL;
         LSR:                         return FnLSR;
         ASR:                         return FnASR;
         LUI:                         return FnLUI;
         default:                     return FnLLI;
      endcase
   endfunction

   function automatic pcSelectT expectedPcSel(input branchT code,
                                              input logic [`FLAG_WIDTH-1:0] stored);
      logic z;
      logic lessThan;
      logic taken;
      z = stored[`FLAGS_Z];
      lessThan = stored[`FLAGS_N] != stored[`FLAGS_V];
      case (code)
         BNE:     taken = !z;
         BE:      taken = z;
         BLT:     taken = lessThan;
         BGE:     taken = !lessThan;
         default: taken = 1'b1;     // Unconditional group
      endcase
      if (code == RET) return PcSysbus;
      return taken ? PcAluOut : Pc1;
   endfunction

   // Returns at the negedge of fetch Cycle3
   task automatic fetchInstruction(input logic [7:0] instr,
                                   input logic [`FLAG_WIDTH-1:0] flagPattern);
      waitForAle();
      @(posedge Clock);
      OpcodeCondIn <= instr;
      Flags        <= flagPattern;
      waitForIrWe();
   endtask

   task automatic testResetAndFetch();
      int irCycle;
      repeat (3) begin
         @(negedge Clock);
         checkBit(|{IrWe, RegWe, PcWe, AluWe, LrWe, LrEn, AluEn, PcEn, MemEn, ENB, ALE}, 1'b0,
                  "Any enable in reset");
         checkBit(nME, 1'b1, "nME in reset");
      end
      @(posedge Clock);
      nReset <= 1'b1;
      @(posedge Clock);             // First edge that sees reset released
      @(negedge Clock);
      checkBit(ALE, 1'b1, "ALE in first cycle after reset");
      checkBit(nME, 1'b1, "nME with ALE");
      repeat (2) begin
         @(negedge Clock);
         checkBit(nME, 1'b0, "nME in fetch read");
         checkBit(nOE, 1'b0, "nOE in fetch read");
      end
      @(negedge Clock);
      checkBit(IrWe, 1'b1, "IrWe in fourth fetch cycle");
      irCycle = cycleCount;
      waitForIrWe();
      checkCount(cycleCount - irCycle, 5, "ALU instruction");
      @(negedge Clock);
   endtask

   task automatic testAluDecode();
      int i;
      opcodeT op;
      for (i = 0; i <= int'(LLI); i++) begin
         op = opcodeT'(i[4:0]);
         fetchInstruction(instructionByte(op, BR), 4'h0);
         @(negedge Clock);          // Execute Cycle0
         checkAluOp(AluOp, expectedFunction(op), op.name());
         checkBit(PcWe, 1'b1, {"PcWe for ", op.name()});
         checkBit(PcEn, 1'b1, {"PcEn for ", op.name()});
         checkBit(RegWe, !(op == CMP || op == CMPI), {"RegWe for ", op.name()});
      end
   endtask

   task automatic testWaitStall(input int stallCycles);
      int aleCycle;
      waitForAle();
      aleCycle = cycleCount;
      @(posedge Clock);
      OpcodeCondIn <= instructionByte(ADD, BR);
      nWait        <= 1'b0;
      repeat (stallCycles + 1) @(posedge Clock);
      nWait <= 1'b1;                // Last low sample ends the stall
      waitForIrWe();
      checkCount(cycleCount - aleCycle, 3 + stallCycles, "Stalled fetch");
      @(negedge Clock);
   endtask

   task automatic testMemoryAccess(input opcodeT op);
      int irCycle;
      int k;
      fetchInstruction(instructionByte(op, BR), 4'h0);
      irCycle = cycleCount;
      @(negedge Clock);
      checkAluOp(AluOp, FnADD, {op.name(), " address"});
      checkImmSel(ImmSel, ImmShort, {op.name(), " address"});
      checkBit(AluWe, 1'b1, {"AluWe in ", op.name(), " Cycle0"});
      checkBit(AluEn, 1'b1, {"AluEn in ", op.name(), " Cycle0"});
      checkBit(ALE, 1'b0, "ALE in execute Cycle0");
      @(negedge Clock);
      checkBit(ALE, 1'b1, "ALE in execute Cycle1");
      for (k = 0; k < 2; k++) begin
         @(negedge Clock);
         checkBit(nME, 1'b0, {"nME in ", op.name(), " access"});
         checkBit(nWE, op != STW, {"nWE in ", op.name(), " access"});
         checkBit(ENB, op == LDW && k == 1, {"ENB in ", op.name(), " access"});
      end
      @(negedge Clock);             // Execute Cycle4
      checkBit(PcWe, 1'b1, "PcWe in execute Cycle4");
      checkBit(RegWe, op == LDW, {"RegWe in ", op.name(), " Cycle4"});
      if (op == LDW) checkWdSel(WdSel, WdSys, "LDW Cycle4");
      @(posedge Clock);
      OpcodeCondIn <= instructionByte(ADD, BR);
      waitForIrWe();
      checkCount(cycleCount - irCycle, 9, {op.name(), " instruction"});
      @(negedge Clock);
   endtask

   task automatic testCarryFlag();
      int randomWord;
      logic [`FLAG_WIDTH-1:0] pattern;
      randomWord = $random(seed);
      pattern = randomWord[`FLAG_WIDTH-1:0];
      fetchInstruction(instructionByte(ADD, BR), pattern);
      @(negedge Clock);
      @(posedge Clock);
      Flags <= ~pattern;            // No capture outside execute
      repeat (4) begin
         @(negedge Clock);
         checkBit(CFlag, pattern[`FLAGS_C], "CFlag after ADD");
      end
      @(negedge Clock);             // Next ADD captures the inverted pattern
      @(negedge Clock);
      checkBit(CFlag, !pattern[`FLAGS_C], "CFlag after second ADD");
   endtask

   task automatic testBranches();
      int p;
      int c;
      logic [`FLAG_WIDTH-1:0] pattern;
      branchT code;
      for (p = 0; p < 16; p++) begin
         pattern = p[`FLAG_WIDTH-1:0];
         fetchInstruction(instructionByte(ADD, BR), pattern);
         @(negedge Clock);
         for (c = 0; c < 8; c++) begin
            code = branchT'(c[2:0]);
            fetchInstruction(instructionByte(BRANCH, code), pattern);
            @(negedge Clock);
            checkPcSel(PcSel, expectedPcSel(code, pattern),
                       $sformatf("%s flags %b", code.name(), pattern));
            checkBit(LrWe, code == BWL, {"LrWe for ", code.name()});
            checkBit(LrEn, code == RET, {"LrEn for ", code.name()});
            checkBit(PcWe, 1'b1, {"PcWe for ", code.name()});
         end
      end
   endtask

   initial begin
      seed         = 32'h3c4a_c2b1;
      nReset       = 1'b0;
      OpcodeCondIn = instructionByte(ADD, BR);
      Flags        = '0;
      nWait        = 1'b1;
      testResetAndFetch();
      testAluDecode();
      testWaitStall(1);
      testWaitStall(4);
      testMemoryAccess(LDW);
      testMemoryAccess(STW);
      testCarryFlag();
      testBranches();
      if (errorCount == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

// ==== compile.f ====
+incdir+include
verilog/opcodePkg.sv
verilog/controlPkg.sv
verilog/statusFlags.sv
verilog/cycleSequencer.sv
verilog/datapathDecoder.sv
verilog/busStrobes.sv
verilog/controlTop.sv
sim/controlTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the control unit testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f compile.f --top-module controlTb -o controlSim \
   && ./obj_dir/controlSim 2>&1 | tee sim.log
grep -q "Simulation finished: PASS" sim.log \
   && echo "Run passed" \
   || { echo "Run failed"; exit 1; }
